// File: verilog/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cpu side word and address
`define DC_WORD_W 16
`define DC_ADDR_W 16 // word addressed, not byte addressed

// line geometry
`define DC_WORDS_PER_LINE 4
`define DC_SETS 32 // sets per way

// field widths of a word address
`define DC_OFFSET_W $clog2(`DC_WORDS_PER_LINE)
`define DC_INDEX_W $clog2(`DC_SETS)
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

// main memory model
`define DC_MEM_LATENCY 4 // busy cycles per request, 2 or more

`endif

// File: verilog/dcache_pkg.sv
`default_nettype none

`include "dcache_cfg.svh"

package dcache_pkg;

	typedef logic [`DC_WORD_W-1:0] word_t;

	// word address as seen by the cache
	typedef struct packed {
		logic [`DC_TAG_W-1:0] tag;
		logic [`DC_INDEX_W-1:0] index;
		logic [`DC_OFFSET_W-1:0] offset; // word within the line
	} addr_t;

	typedef struct packed {
		logic [`DC_TAG_W-1:0] tag;
		logic [`DC_INDEX_W-1:0] index;
	} line_addr_t;

	// word 0 sits in the low bits
	typedef logic [`DC_WORDS_PER_LINE-1:0][`DC_WORD_W-1:0] line_data_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		logic [`DC_TAG_W-1:0] tag;
		line_data_t data;
	} way_entry_t;

	typedef struct packed {
		logic we; // 1 = write, 0 = read
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic hit; // line was present at lookup
		word_t rdata;
	} cpu_rsp_t;

	typedef struct packed {
		logic we;
		line_addr_t addr;
		line_data_t data; // only used on writes
	} mem_req_t;

	typedef struct packed {
		line_data_t data;
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: verilog/sync_ram.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_cfg.svh"

module sync_ram #(
	parameter type t_entry = logic,
	parameter int DEPTH = `DC_SETS
) (
	input  wire logic                     clk,
	input  wire logic                     rst,
	input  wire logic [$clog2(DEPTH)-1:0] i_index,
	input  wire logic                     i_we,
	input  wire t_entry                   i_wdata,
	output t_entry                        o_rdata
);

	t_entry mem [DEPTH];

	// whole array clears in the reset cycle, so lines come up invalid and lru zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (i_we) begin
			mem[i_index] <= i_wdata;
		end
	end

	// read returns the old entry when the same index is written
	always_ff @(posedge clk) begin
		o_rdata <= mem[i_index];
	end

	a_index_known : assert property (
		@(posedge clk) disable iff (rst)
		i_we |-> !$isunknown(i_index)
	) else $error("sync_ram: write with unknown index");

endmodule

`default_nettype wire

// File: verilog/main_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_cfg.svh"

module main_mem import dcache_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     i_req_valid,
	input  wire mem_req_t i_req,
	output logic          o_req_ready,
	output logic          o_rsp_valid,
	output mem_rsp_t      o_rsp
);

	localparam int CNT_W = $clog2(`DC_MEM_LATENCY);
	localparam int LINES = 2 ** $bits(line_addr_t);

	typedef enum logic {
		ST_WAIT,
		ST_COUNT
	} state_t;

	state_t state;
	logic [CNT_W-1:0] cnt;
	mem_req_t req_q; // request being served
	logic req_fire;
	logic last_cnt;

	line_data_t mem [LINES] = '{default: '0};

	assign o_req_ready = (state == ST_WAIT);
	assign req_fire = i_req_valid && o_req_ready;
	assign last_cnt = (state == ST_COUNT) && (cnt == '0);

	// wait/count machine that pulses the response DC_MEM_LATENCY cycles after accept
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_WAIT;
			cnt <= '0;
			o_rsp_valid <= 1'b0;
		end else begin
			o_rsp_valid <= last_cnt;
			case (state)
				ST_WAIT: begin
					if (req_fire) begin
						state <= ST_COUNT;
						cnt <= CNT_W'(`DC_MEM_LATENCY - 1); // pulse is registered
					end
				end
				ST_COUNT: begin
					if (last_cnt) begin
						state <= ST_WAIT;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_fire) begin
			req_q <= i_req;
		end
		if (last_cnt) begin
			if (req_q.we) begin
				mem[req_q.addr] <= req_q.data;
			end
			o_rsp.data <= req_q.we ? req_q.data : mem[req_q.addr]; // write echoes its line
		end
	end

	a_busy_no_accept : assert property (
		@(posedge clk) disable iff (rst)
		req_fire |=> !req_fire [*`DC_MEM_LATENCY]
	) else $error("main_mem: request accepted while busy");

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_cfg.svh"

module cache_ctrl import dcache_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   i_req_valid,
	input  wire cpu_req_t               i_req,
	output logic                        o_req_ready,
	output logic                        o_rsp_valid,
	output cpu_rsp_t                    o_rsp,
	input  wire logic                   i_rsp_ready,
	output logic [`DC_INDEX_W-1:0]      o_way_index,
	output logic                        o_way0_we,
	output logic                        o_way1_we,
	output way_entry_t                  o_way_wdata,
	input  wire way_entry_t             i_way0_rdata,
	input  wire way_entry_t             i_way1_rdata,
	output logic                        o_lru_we,
	output logic                        o_lru_wdata,
	input  wire logic                   i_lru_rdata,
	output logic                        o_mem_req_valid,
	output mem_req_t                    o_mem_req,
	input  wire logic                   i_mem_req_ready,
	input  wire logic                   i_mem_rsp_valid,
	input  wire mem_rsp_t               i_mem_rsp
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,  // tags of both ways are on the ram outputs
		ST_EVICT,   // dirty victim goes back to memory
		ST_FETCH,
		ST_FILL,
		ST_RESPOND
	} state_t;

	state_t state;
	cpu_req_t req_q;
	cpu_rsp_t rsp_q;
	logic victim_q;     // way being replaced on a miss
	logic mem_sent_q;   // memory took the request and its pulse is awaited
	line_data_t fill_q; // line returned by the fetch

	logic hit0;
	logic hit1;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_sel;
	way_entry_t hit_entry;
	way_entry_t victim_entry;
	line_data_t base_line;
	line_data_t new_line;
	word_t rsp_word;

	// put one word into a line at the given offset
	function automatic line_data_t merge_word(
		input line_data_t line,
		input logic [`DC_OFFSET_W-1:0] offset,
		input word_t wdata
	);
		line_data_t merged;
		merged = line;
		merged[offset] = wdata;
		return merged;
	endfunction

	// arrays are read with the incoming index while idle, then held on the stored one
	assign o_way_index = (state == ST_IDLE) ? i_req.addr.index : req_q.addr.index;

	assign hit0 = i_way0_rdata.valid && (i_way0_rdata.tag == req_q.addr.tag);
	assign hit1 = i_way1_rdata.valid && (i_way1_rdata.tag == req_q.addr.tag);
	assign hit = hit0 || hit1;
	assign hit_way = !hit0;
	assign hit_entry = hit_way ? i_way1_rdata : i_way0_rdata;

	// invalid way 0, then invalid way 1, else the way not used last
	assign victim_way = !i_way0_rdata.valid ? 1'b0 :
		!i_way1_rdata.valid ? 1'b1 : !i_lru_rdata;
	// ways are not written before fill, so their outputs still hold the victim
	assign victim_sel = (state == ST_LOOKUP) ? victim_way : victim_q;
	assign victim_entry = victim_sel ? i_way1_rdata : i_way0_rdata;

	assign base_line = (state == ST_FILL) ? fill_q : hit_entry.data;
	assign new_line = req_q.we ? merge_word(base_line, req_q.addr.offset, req_q.wdata) : base_line;
	assign rsp_word = req_q.we ? req_q.wdata : base_line[req_q.addr.offset];

	assign o_req_ready = (state == ST_IDLE);
	assign o_rsp_valid = (state == ST_RESPOND);
	assign o_rsp = rsp_q;

	always_comb begin
		o_way0_we = 1'b0;
		o_way1_we = 1'b0;
		o_way_wdata.valid = 1'b1;
		o_way_wdata.dirty = req_q.we; // a read fill stays clean
		o_way_wdata.tag = req_q.addr.tag;
		o_way_wdata.data = new_line;
		o_lru_we = (state == ST_LOOKUP);
		o_lru_wdata = hit ? hit_way : victim_way; // way used by this request
		case (state)
			ST_LOOKUP: begin
				if (hit && req_q.we) begin
					o_way0_we = !hit_way;
					o_way1_we = hit_way;
				end
			end
			ST_FILL: begin
				o_way0_we = !victim_q;
				o_way1_we = victim_q;
			end
			default: ;
		endcase
	end

	always_comb begin
		o_mem_req_valid = ((state == ST_EVICT) || (state == ST_FETCH)) && !mem_sent_q;
		o_mem_req.we = (state == ST_EVICT);
		o_mem_req.data = victim_entry.data;
		o_mem_req.addr.index = req_q.addr.index;
		if (state == ST_EVICT) begin
			o_mem_req.addr.tag = victim_entry.tag;
		end else begin
			o_mem_req.addr.tag = req_q.addr.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			mem_sent_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_req_valid) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (hit) begin
						state <= ST_RESPOND;
					end else if (victim_entry.valid && victim_entry.dirty) begin
						state <= ST_EVICT;
					end else begin
						state <= ST_FETCH;
					end
				end
				ST_EVICT, ST_FETCH: begin
					if (o_mem_req_valid && i_mem_req_ready) begin
						mem_sent_q <= 1'b1;
					end
					if (i_mem_rsp_valid) begin
						mem_sent_q <= 1'b0;
						state <= (state == ST_EVICT) ? ST_FETCH : ST_FILL;
					end
				end
				ST_FILL: state <= ST_RESPOND;
				ST_RESPOND: begin
					if (i_rsp_ready) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_req_valid && o_req_ready) begin
			req_q <= i_req;
		end
		if (state == ST_LOOKUP) begin
			victim_q <= victim_way;
			rsp_q.hit <= hit;
			rsp_q.rdata <= rsp_word; // final on a hit, replaced at fill on a miss
		end
		if ((state == ST_FETCH) && i_mem_rsp_valid) begin
			fill_q <= i_mem_rsp.data;
		end
		if (state == ST_FILL) begin
			rsp_q.rdata <= rsp_word;
		end
	end

	a_rsp_stable : assert property (
		@(posedge clk) disable iff (rst)
		(o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp))
	) else $error("cache_ctrl: response changed before it was taken");

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_cfg.svh"

module dcache_top import dcache_pkg::*; (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     i_req_valid,
	input  wire cpu_req_t i_req,
	output logic          o_req_ready,
	output logic          o_rsp_valid,
	output cpu_rsp_t      o_rsp,
	input  wire logic     i_rsp_ready
);

	logic [`DC_INDEX_W-1:0] way_index; // shared by both ways and the lru store
	logic way0_we;
	logic way1_we;
	way_entry_t way_wdata;
	way_entry_t way0_rdata;
	way_entry_t way1_rdata;
	logic lru_we;
	logic lru_wdata;
	logic lru_rdata;

	logic mem_req_valid;
	mem_req_t mem_req;
	logic mem_req_ready;
	logic mem_rsp_valid;
	mem_rsp_t mem_rsp;

	cache_ctrl u_cache_ctrl (
		.clk(clk),
		.rst(rst),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.o_req_ready(o_req_ready),
		.o_rsp_valid(o_rsp_valid),
		.o_rsp(o_rsp),
		.i_rsp_ready(i_rsp_ready),
		.o_way_index(way_index),
		.o_way0_we(way0_we),
		.o_way1_we(way1_we),
		.o_way_wdata(way_wdata),
		.i_way0_rdata(way0_rdata),
		.i_way1_rdata(way1_rdata),
		.o_lru_we(lru_we),
		.o_lru_wdata(lru_wdata),
		.i_lru_rdata(lru_rdata),
		.o_mem_req_valid(mem_req_valid),
		.o_mem_req(mem_req),
		.i_mem_req_ready(mem_req_ready),
		.i_mem_rsp_valid(mem_rsp_valid),
		.i_mem_rsp(mem_rsp)
	);

	sync_ram #(.t_entry(way_entry_t)) way0_ram (.clk(clk), .rst(rst), .i_index(way_index),
		.i_we(way0_we), .i_wdata(way_wdata), .o_rdata(way0_rdata));

	sync_ram #(.t_entry(way_entry_t)) way1_ram (.clk(clk), .rst(rst), .i_index(way_index),
		.i_we(way1_we), .i_wdata(way_wdata), .o_rdata(way1_rdata));

	// one bit per set holding the most recently used way
	sync_ram #(.t_entry(logic)) lru_ram (.clk(clk), .rst(rst), .i_index(way_index),
		.i_we(lru_we), .i_wdata(lru_wdata), .o_rdata(lru_rdata));

	main_mem u_main_mem (
		.clk(clk),
		.rst(rst),
		.i_req_valid(mem_req_valid),
		.i_req(mem_req),
		.o_req_ready(mem_req_ready),
		.o_rsp_valid(mem_rsp_valid),
		.o_rsp(mem_rsp)
	);

endmodule

`default_nettype wire

// File: verification/tb_dcache.sv
`timescale 1ns/100ps
`default_nettype none

`include "dcache_cfg.svh"

module tb_dcache import dcache_pkg::*; ();

	localparam int TIMEOUT = 200; // cycles per wait
	localparam int NUM_RANDOM = 500;

	logic clk;
	logic rst;
	logic i_req_valid;
	cpu_req_t i_req;
	logic o_req_ready;
	logic o_rsp_valid;
	cpu_rsp_t o_rsp;
	logic i_rsp_ready;

	integer seed;
	int n_req;
	int n_hit;

	// reference model with a flat memory image plus per-set tag state
	word_t model_mem [2**`DC_ADDR_W];
	logic model_valid [`DC_SETS][2];
	logic [`DC_TAG_W-1:0] model_tag [`DC_SETS][2];
	logic model_lru [`DC_SETS]; // most recently used way
	logic [`DC_TAG_W-1:0] tag_pool [4];

	dcache_top UUT (
		.clk(clk),
		.rst(rst),
		.i_req_valid(i_req_valid),
		.i_req(i_req),
		.o_req_ready(o_req_ready),
		.o_rsp_valid(o_rsp_valid),
		.o_rsp(o_rsp),
		.i_rsp_ready(i_rsp_ready)
	);

	always #4 clk = ~clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic check_rsp(input cpu_rsp_t got, input cpu_rsp_t exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("Error: time %0t %s got hit=%b rdata=%h expected hit=%b rdata=%h",
				$time, name, got.hit, got.rdata, exp.hit, exp.rdata));
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string name);
		if (got !== exp) begin
			abort_run($sformatf("Error: time %0t %s got %h expected %h", $time, name, got, exp));
		end
	endtask

	function automatic cpu_req_t build_req(input logic we, input logic [`DC_TAG_W-1:0] tag,
		input logic [`DC_INDEX_W-1:0] index, input logic [`DC_OFFSET_W-1:0] offset,
		input word_t wdata);
		cpu_req_t req;
		req.we = we;
		req.addr.tag = tag;
		req.addr.index = index;
		req.addr.offset = offset;
		req.wdata = wdata;
		return req;
	endfunction

	// few sets and four tags, so two ways overflow often
	task automatic make_req(output cpu_req_t req);
		integer r;
		integer d;
		r = $random(seed);
		d = $random(seed);
		req.we = r[0];
		req.addr.tag = tag_pool[r[2:1]];
		req.addr.index = '0;
		req.addr.index[2:0] = r[5:3];
		req.addr.offset = r[7:6];
		req.wdata = d[15:0];
	endtask

	// hit check, then invalid way 0, invalid way 1, else the way not used last
	task automatic predict(input cpu_req_t req, output cpu_rsp_t exp);
		int set;
		logic way;
		logic found;
		set = req.addr.index;
		found = 1'b0;
		way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (model_valid[set][w] && (model_tag[set][w] == req.addr.tag)) begin
				found = 1'b1;
				way = w[0];
			end
		end
		if (!found) begin
			if (!model_valid[set][0]) begin
				way = 1'b0;
			end else if (!model_valid[set][1]) begin
				way = 1'b1;
			end else begin
				way = !model_lru[set];
			end
			model_valid[set][way] = 1'b1;
			model_tag[set][way] = req.addr.tag;
		end
		model_lru[set] = way;
		if (req.we) begin
			model_mem[req.addr] = req.wdata;
		end
		exp.hit = found;
		exp.rdata = model_mem[req.addr]; // written word on a write
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!o_req_ready) begin
			if (cycles >= TIMEOUT) begin
				abort_run("timeout while waiting for o_req_ready");
			end
			@(negedge clk);
			cycles++;
		end
	endtask

	// one request, its response and an optional stall of the response port
	task automatic run_request(input cpu_req_t req, input int stall, output cpu_rsp_t got);
		cpu_rsp_t exp;
		cpu_req_t junk;
		int cycles;
		predict(req, exp);
		wait_ready();
		@(posedge clk);
		i_req_valid <= 1'b1;
		i_req <= req;
		@(negedge clk);
		if (!o_req_ready) begin
			abort_run("o_req_ready dropped while the cache was idle");
		end
		@(posedge clk); // accepted here
		i_req_valid <= 1'b0;
		i_rsp_ready <= (stall == 0);
		cycles = 1;
		@(negedge clk);
		while (!o_rsp_valid) begin
			if (cycles >= TIMEOUT) begin
				abort_run("timeout while waiting for o_rsp_valid");
			end
			@(negedge clk);
			cycles++;
		end
		got = o_rsp;
		check_rsp(got, exp, "o_rsp");
		if (exp.hit && (cycles != 2)) begin
			abort_run($sformatf("hit response came %0d cycles after accept, not 2", cycles));
		end
		for (int i = 0; i < stall; i++) begin
			make_req(junk);
			@(posedge clk);
			i_req_valid <= 1'b1; // offered while the response is pending
			i_req <= junk;
			@(negedge clk);
			if (!o_rsp_valid) begin
				abort_run("o_rsp_valid dropped before the response was taken");
			end
			if (o_req_ready) begin
				abort_run("o_req_ready rose while a response was still pending");
			end
			check_rsp(o_rsp, got, "o_rsp (held)");
		end
		if (stall > 0) begin
			@(posedge clk);
			i_rsp_ready <= 1'b1;
		end
		@(posedge clk); // response taken
		i_req_valid <= 1'b0;
		n_req++;
		if (exp.hit) begin
			n_hit++;
		end
	endtask

	initial begin
		cpu_req_t req;
		cpu_rsp_t got;
		integer r;
		clk = 1'b0;
		rst = 1'b1;
		i_req_valid = 1'b0;
		i_req = '0;
		i_rsp_ready = 1'b1;
		seed = 32;
		n_req = 0;
		n_hit = 0;
		tag_pool[0] = 'h000;
		tag_pool[1] = 'h0a5;
		tag_pool[2] = 'h155;
		tag_pool[3] = 'h1ff;
		for (int a = 0; a < 2**`DC_ADDR_W; a++) begin
			model_mem[a] = '0;
		end
		for (int s = 0; s < `DC_SETS; s++) begin
			model_valid[s][0] = 1'b0;
			model_valid[s][1] = 1'b0;
			model_lru[s] = 1'b0;
		end

		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (o_rsp_valid || !o_req_ready) begin
			abort_run("handshake outputs are wrong after reset");
		end

		// first read misses and sees zero memory
		run_request(build_req(1'b0, 'h0a5, 5'd3, 2'd1, '0), 0, got);
		check_word(got.rdata, 16'h0000, "o_rsp.rdata");

		// write miss allocates, then write hit, each read back
		run_request(build_req(1'b1, 'h033, 5'd12, 2'd2, 16'hbeef), 0, got);
		run_request(build_req(1'b0, 'h033, 5'd12, 2'd2, '0), 0, got);
		check_word(got.rdata, 16'hbeef, "o_rsp.rdata");
		run_request(build_req(1'b1, 'h033, 5'd12, 2'd0, 16'h1234), 2, got);
		run_request(build_req(1'b0, 'h033, 5'd12, 2'd0, '0), 0, got);
		check_word(got.rdata, 16'h1234, "o_rsp.rdata");

		// three tags in one set send dirty victims out and back
		run_request(build_req(1'b1, 'h011, 5'd20, 2'd3, 16'haaaa), 0, got);
		run_request(build_req(1'b1, 'h022, 5'd20, 2'd3, 16'hbbbb), 0, got);
		run_request(build_req(1'b0, 'h011, 5'd20, 2'd3, '0), 0, got);
		run_request(build_req(1'b1, 'h044, 5'd20, 2'd3, 16'hcccc), 1, got);
		run_request(build_req(1'b0, 'h022, 5'd20, 2'd3, '0), 0, got);
		check_word(got.rdata, 16'hbbbb, "o_rsp.rdata");
		run_request(build_req(1'b0, 'h011, 5'd20, 2'd3, '0), 0, got);
		check_word(got.rdata, 16'haaaa, "o_rsp.rdata");
		run_request(build_req(1'b0, 'h044, 5'd20, 2'd3, '0), 3, got);
		check_word(got.rdata, 16'hcccc, "o_rsp.rdata");

		// clean lines only, so victims are dropped
		for (int k = 0; k < 6; k++) begin
			run_request(build_req(1'b0, 9'(k % 3), 5'd25, 2'(k), '0), 0, got);
		end

		for (int n = 0; n < NUM_RANDOM; n++) begin
			make_req(req);
			r = $random(seed);
			run_request(req, (r[1:0] == 2'b00) ? int'(r[4:2]) : 0, got);
		end

		$display("%0d requests checked, %0d hits", n_req, n_hit);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dcache.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/sync_ram.sv
verilog/main_mem.sv
verilog/cache_ctrl.sv
verilog/dcache_top.sv
verification/tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# builds the dcache testbench with verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dcache -f dcache.f -o tb_dcache \
	&& ./obj_dir/tb_dcache > sim.log 2>&1 \
	|| echo "build or simulation stopped with an error"

cat sim.log 2>/dev/null

grep -q "ALL TESTS PASSED" sim.log 2>/dev/null \
	&& { echo "result: pass"; exit 0; } \
	|| { echo "result: fail"; exit 1; }
